// ==== Bender.yml ====
package:
  name: ring_router_input

sources:
  - ring_net_pkg.sv
  - ring_msg_if.sv
  - ring_inject.sv
  - ring_input_queue.sv
  - ring_route_compute.sv
  - ring_router_input_top.sv
  - target: test
    files:
      - ring_router_input_assert.sv
      - ring_router_input_tb.sv

// ==== ring_inject.sv ====
//==========================================================================
// no handshake towards the terminal, a refused message is lost and flagged
// by a single-cycle drop pulse
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module ring_inject #(
  parameter int unsigned router_id = 0
) (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  logic                                     in_val,
  input  logic [ring_net_pkg::dest_nbits-1:0]      in_dest,
  input  logic [ring_net_pkg::payload_nbits-1:0]   in_payload,
  input  logic [ring_net_pkg::count_nbits-1:0]     enq_free,
  output logic                                     enq_val,
  output ring_net_pkg::ring_msg_t                  enq_msg,
  output logic                                     drop
);

  logic [ring_net_pkg::seq_nbits-1:0] seq_cnt;
  logic                               refuse;
  logic                               accept;

  // enq_free does not yet count the message sitting in our own register,
  // so with one free slot left and a message pending there is no room
  assign refuse = (enq_free == '0) ||
                  ((enq_free == ring_net_pkg::count_nbits'(1)) && enq_val);
  assign accept = in_val && !refuse;

  // control path, the strobe and drop pulse are each one cycle long
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enq_val <= 1'b0;
      drop    <= 1'b0;
      seq_cnt <= '0;
    end else begin
      enq_val <= accept;
      drop    <= in_val && refuse;
      // dropped messages do not consume a sequence number
      if (accept) begin
        seq_cnt <= seq_cnt + 1'b1;
      end
    end
  end

  // stamp the source id and the sequence number on the way in
  always_ff @(posedge clk) begin
    if (accept) begin
      enq_msg.dest    <= in_dest;
      enq_msg.src     <= ring_net_pkg::dest_nbits'(router_id);
      enq_msg.seq     <= seq_cnt;
      enq_msg.payload <= in_payload;
    end
  end

endmodule

`default_nettype wire

// ==== ring_input_queue.sv ====
//==========================================================================
// in-order queue of queue_depth entries, a push and a pop may share a cycle
// a push into a full queue is ignored unless the head pops in that cycle
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module ring_input_queue #(
  parameter type t_item = ring_net_pkg::ring_msg_t
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   enq_val,
  input  t_item                                  enq_data,
  output logic [ring_net_pkg::count_nbits-1:0]   enq_free,
  output logic [ring_net_pkg::free_nbits-1:0]    free_level,
  ring_msg_if.buf_side                           q
);

  //==========================================================================
  // storage and pointers
  //==========================================================================

  t_item                                mem [ring_net_pkg::queue_depth];
  logic [ring_net_pkg::ptr_nbits-1:0]   wr_ptr;
  logic [ring_net_pkg::ptr_nbits-1:0]   rd_ptr;
  logic [ring_net_pkg::count_nbits-1:0] count;
  logic [ring_net_pkg::count_nbits-1:0] free_cnt;
  logic                                 full;
  logic                                 empty;
  logic                                 push;
  logic                                 pop;

  assign empty = (count == '0);
  assign full  = (count == ring_net_pkg::count_nbits'(ring_net_pkg::queue_depth));

  // a pop is ignored on an empty queue, the route stage should never ask
  assign pop  = q.deq && !empty;
  // when full, the pop frees the head entry which the push then overwrites
  assign push = enq_val && (!full || pop);

  // pointers wrap on their own since queue_depth is a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= enq_data;
    end
  end

  //==========================================================================
  // head and level outputs
  //==========================================================================

  assign q.head_val = !empty;
  assign q.head_msg = mem[rd_ptr];

  assign free_cnt   = ring_net_pkg::count_nbits'(ring_net_pkg::queue_depth) - count;
  assign enq_free   = free_cnt;
  assign q.num_free = free_cnt;

  // neighbours only see 0, 1 or 2 free entries, more than two reads as two
  assign free_level =
    (free_cnt > ring_net_pkg::count_nbits'(ring_net_pkg::free_max)) ?
    ring_net_pkg::free_nbits'(ring_net_pkg::free_max) :
    free_cnt[ring_net_pkg::free_nbits-1:0];

endmodule

`default_nettype wire

// ==== ring_msg_if.sv ====
//==========================================================================
// head of the input queue, seen by the route stage
// deq may only pulse while head_val is high
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

interface ring_msg_if #(
  parameter type t_item = ring_net_pkg::ring_msg_t
);

  // the queue holds at least one entry
  logic head_val;
  // oldest entry, only meaningful while head_val is high
  t_item head_msg;
  // pop strobe, the head leaves the queue at the next rising edge
  logic deq;
  // number of empty entries, carried along for checking the queue from outside
  logic [ring_net_pkg::count_nbits-1:0] num_free;

  modport buf_side (
    output head_val,
    output head_msg,
    output num_free,
    input  deq
  );

  modport route_side (
    input  head_val,
    input  head_msg,
    input  num_free,
    output deq
  );

endinterface

`default_nettype wire

// ==== ring_net_pkg.sv ====
//==========================================================================
// ring size must be a power of two, since hop counts wrap in dest_nbits
// queue_depth must also be a power of two for the queue pointers to wrap
//==========================================================================

`default_nettype none

package ring_net_pkg;

  //==========================================================================
  // ring geometry and field widths
  //==========================================================================

  // eight routers on a bidirectional ring, ids 0 to 7
  localparam int unsigned num_routers = 8;
  localparam int unsigned dest_nbits  = $clog2(num_routers);

  // a channel free level only takes the values 0, 1 and 2
  localparam int unsigned free_nbits = 2;
  localparam int unsigned free_max   = 2;

  localparam int unsigned seq_nbits     = 4;
  localparam int unsigned payload_nbits = 8;

  //==========================================================================
  // input queue sizing
  //==========================================================================

  localparam int unsigned queue_depth = 4;
  localparam int unsigned ptr_nbits   = $clog2(queue_depth);
  // the occupancy and free counts must be able to hold the value queue_depth
  localparam int unsigned count_nbits = $clog2(queue_depth + 1);

  // a load factor is at most 7 hops plus 2 missing entries on two channels
  localparam int unsigned factor_nbits = 5;

  //==========================================================================
  // one-hot route requests
  //==========================================================================

  localparam logic [2:0] req_west = 3'b001;
  localparam logic [2:0] req_term = 3'b010;
  localparam logic [2:0] req_east = 3'b100;

  // message as it travels through the router, 18 bits with dest on top
  typedef struct packed {
    logic [dest_nbits-1:0]    dest;
    logic [dest_nbits-1:0]    src;
    logic [seq_nbits-1:0]     seq;
    logic [payload_nbits-1:0] payload;
  } ring_msg_t;

endpackage

`default_nettype wire

// ==== ring_route_compute.sv ====
//==========================================================================
// adaptive west or east choice by hop count plus neighbour channel load
// the output register holds its message while out_stall is high
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module ring_route_compute #(
  parameter int unsigned router_id = 0
) (
  input  logic                                  clk,
  input  logic                                  arst_n,
  ring_msg_if.route_side                        q,
  input  logic [ring_net_pkg::free_nbits-1:0]   forw_free_one,
  input  logic [ring_net_pkg::free_nbits-1:0]   forw_free_two,
  input  logic [ring_net_pkg::free_nbits-1:0]   backw_free_one,
  input  logic [ring_net_pkg::free_nbits-1:0]   backw_free_two,
  input  logic                                  out_stall,
  output logic                                  out_val,
  output logic [2:0]                            out_reqs,
  output ring_net_pkg::ring_msg_t               out_msg
);

  logic [ring_net_pkg::dest_nbits-1:0]   cur;
  logic [ring_net_pkg::dest_nbits-1:0]   east_hops;
  logic [ring_net_pkg::dest_nbits-1:0]   west_hops;
  logic                                  one_hop;
  logic [ring_net_pkg::factor_nbits-1:0] east_factor;
  logic [ring_net_pkg::factor_nbits-1:0] west_factor;
  logic [2:0]                            reqs;
  logic                                  can_load;

  // missing entries on a channel, a level above free_max counts as none missing
  function automatic logic [ring_net_pkg::factor_nbits-1:0] missing(
    input logic [ring_net_pkg::free_nbits-1:0] level
  );
    if (level >= ring_net_pkg::free_nbits'(ring_net_pkg::free_max)) begin
      return '0;
    end
    return ring_net_pkg::factor_nbits'(ring_net_pkg::free_max) -
           ring_net_pkg::factor_nbits'(level);
  endfunction

  assign cur = ring_net_pkg::dest_nbits'(router_id);

  //==========================================================================
  // route decision for the head message
  //==========================================================================

  always_comb begin
    // both distances wrap modulo the ring size, so they always sum to it
    east_hops = q.head_msg.dest - cur;
    west_hops = cur - q.head_msg.dest;
    // a direct neighbour in either direction only needs the first channel
    one_hop   = (east_hops == 1) || (west_hops == 1);

    // east travels through the forward channels, west through the backward ones
    east_factor = ring_net_pkg::factor_nbits'(east_hops) + missing(forw_free_one);
    west_factor = ring_net_pkg::factor_nbits'(west_hops) + missing(backw_free_one);
    if (!one_hop) begin
      east_factor = east_factor + missing(forw_free_two);
      west_factor = west_factor + missing(backw_free_two);
    end

    // ties go east, west must be strictly cheaper
    if (q.head_msg.dest == cur) begin
      reqs = ring_net_pkg::req_term;
    end else if (west_factor < east_factor) begin
      reqs = ring_net_pkg::req_west;
    end else begin
      reqs = ring_net_pkg::req_east;
    end
  end

  //==========================================================================
  // output register
  //==========================================================================

  // the register may take a new message unless it holds a stalled one
  assign can_load = !out_val || !out_stall;
  assign q.deq    = q.head_val && can_load;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_val  <= 1'b0;
      out_reqs <= '0;
    end else if (can_load) begin
      out_val <= q.head_val;
      if (q.head_val) begin
        out_reqs <= reqs;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (q.deq) begin
      out_msg <= q.head_msg;
    end
  end

endmodule

`default_nettype wire

// ==== ring_router_input_assert.sv ====
//==========================================================================
// bound into ring_route_compute, checks are off while arst_n is low
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module ring_router_input_assert (
  input logic                                 clk,
  input logic                                 arst_n,
  input logic                                 head_val,
  input logic                                 deq,
  input logic [ring_net_pkg::count_nbits-1:0] num_free,
  input logic                                 out_stall,
  input logic                                 out_val,
  input logic [2:0]                           out_reqs,
  input ring_net_pkg::ring_msg_t              out_msg
);

  // exactly one output is requested for a valid message
  reqs_one_hot: assert property (@(posedge clk) disable iff (!arst_n)
    out_val |-> $onehot(out_reqs))
    else $error("out_reqs is not one-hot while out_val is high");

  // popping an empty queue would lose track of the pointers, and the free
  // count must agree that the queue still holds an entry
  deq_needs_head: assert property (@(posedge clk) disable iff (!arst_n)
    deq |-> (head_val &&
             (num_free < ring_net_pkg::count_nbits'(ring_net_pkg::queue_depth))))
    else $error("deq pulsed while the queue was empty");

  // the switch sees the same message for as long as it stalls
  stall_holds_output: assert property (@(posedge clk) disable iff (!arst_n)
    (out_val && out_stall) |=> (out_val && $stable(out_reqs) && $stable(out_msg)))
    else $error("output changed while stalled");

endmodule

bind ring_route_compute ring_router_input_assert assert0 (
  .clk       (clk),
  .arst_n    (arst_n),
  .head_val  (q.head_val),
  .deq       (q.deq),
  .num_free  (q.num_free),
  .out_stall (out_stall),
  .out_val   (out_val),
  .out_reqs  (out_reqs),
  .out_msg   (out_msg)
);

`default_nettype wire

// ==== ring_router_input_tb.sv ====
//==========================================================================
// directed tests for the router input side with router_id 3
// neighbour levels stay fixed while a message is between injection and output
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module ring_router_input_tb;

  localparam int unsigned router_id   = 3;
  localparam int unsigned clk_period  = 100;
  localparam int unsigned max_wait    = 10;
  // about 40 messages of at most max_wait + 3 cycles each, plus stall time
  localparam int unsigned test_cycles = 40 * (max_wait + 3) + 60;
  localparam int unsigned timeout_ns  = (test_cycles + 3) * clk_period;

  logic                                   clk;
  logic                                   arst_n;
  logic                                   in_val;
  logic [ring_net_pkg::dest_nbits-1:0]    in_dest;
  logic [ring_net_pkg::payload_nbits-1:0] in_payload;
  logic                                   drop;
  logic [ring_net_pkg::free_nbits-1:0]    free_level;
  logic [ring_net_pkg::free_nbits-1:0]    forw_free_one;
  logic [ring_net_pkg::free_nbits-1:0]    forw_free_two;
  logic [ring_net_pkg::free_nbits-1:0]    backw_free_one;
  logic [ring_net_pkg::free_nbits-1:0]    backw_free_two;
  logic                                   out_stall;
  logic                                   out_val;
  logic [2:0]                             out_reqs;
  ring_net_pkg::ring_msg_t                out_msg;

  int unsigned                        errors;
  int unsigned                        checks;
  // sequence number the next accepted message should carry
  logic [ring_net_pkg::seq_nbits-1:0] seq_next;

  ring_router_input_top #(.router_id(router_id)) dut0 (
    .clk            (clk),
    .arst_n         (arst_n),
    .in_val         (in_val),
    .in_dest        (in_dest),
    .in_payload     (in_payload),
    .drop           (drop),
    .free_level     (free_level),
    .forw_free_one  (forw_free_one),
    .forw_free_two  (forw_free_two),
    .backw_free_one (backw_free_one),
    .backw_free_two (backw_free_two),
    .out_stall      (out_stall),
    .out_val        (out_val),
    .out_reqs       (out_reqs),
    .out_msg        (out_msg)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  //==========================================================================
  // reference model and helpers
  //==========================================================================

  // hop count plus missing entries per direction, second channel only beyond
  // one hop, and west has to be strictly cheaper
  function automatic logic [2:0] expected_request(input logic [2:0] dest);
    int east_hops;
    int west_hops;
    int east_load;
    int west_load;
    east_hops = (int'(dest) + ring_net_pkg::num_routers - router_id) %
                ring_net_pkg::num_routers;
    west_hops = ring_net_pkg::num_routers - east_hops;
    east_load = east_hops + ring_net_pkg::free_max - int'(forw_free_one);
    west_load = west_hops + ring_net_pkg::free_max - int'(backw_free_one);
    if (east_hops > 1 && west_hops > 1) begin
      east_load = east_load + ring_net_pkg::free_max - int'(forw_free_two);
      west_load = west_load + ring_net_pkg::free_max - int'(backw_free_two);
    end
    if (east_hops == 0) begin
      return ring_net_pkg::req_term;
    end
    if (west_load < east_load) begin
      return ring_net_pkg::req_west;
    end
    return ring_net_pkg::req_east;
  endfunction

  task automatic set_levels(input int f1, input int f2, input int b1, input int b2);
    @(posedge clk);
    forw_free_one  <= 2'(f1);
    forw_free_two  <= 2'(f2);
    backw_free_one <= 2'(b1);
    backw_free_two <= 2'(b2);
  endtask

  // one-cycle strobe, the message is sampled at the second edge
  task automatic send_msg(input logic [2:0] dest, input bit accepted,
                          output ring_net_pkg::ring_msg_t exp);
    logic [7:0] payload;
    payload = 8'($urandom);
    @(posedge clk);
    in_val     <= 1'b1;
    in_dest    <= dest;
    in_payload <= payload;
    @(posedge clk);
    in_val <= 1'b0;
    exp.dest    = dest;
    exp.src     = 3'(router_id);
    exp.seq     = seq_next;
    exp.payload = payload;
    if (accepted) begin
      seq_next = seq_next + 1'b1;
    end
  endtask

  task automatic check_out(input ring_net_pkg::ring_msg_t exp, input logic [2:0] exp_req);
    int n;
    n = 0;
    @(negedge clk);
    while (!out_val && n < max_wait) begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (out_val) else begin
      errors++;
      $display("no out_val within %0d cycles for a message to %0d", max_wait, exp.dest);
    end
    if (out_val) begin
      assert (out_reqs == exp_req) else begin
        errors++;
        $display("mismatch out_reqs: got %h expected %h (dest %h)", out_reqs, exp_req, exp.dest);
      end
      assert (out_msg == exp) else begin
        errors++;
        $display("mismatch out_msg: got %h expected %h", out_msg, exp);
      end
    end
  endtask

  task automatic route_one(input logic [2:0] dest);
    ring_net_pkg::ring_msg_t m;
    send_msg(dest, 1'b1, m);
    check_out(m, expected_request(dest));
  endtask

  //==========================================================================
  // directed tests
  //==========================================================================

  task automatic test_terminal();
    set_levels(2, 2, 2, 2);
    repeat (3) route_one(3'd3);
  endtask

  // equal loads, so only the hop count decides and dest 7 ties east
  task automatic test_shortest();
    set_levels(2, 2, 2, 2);
    for (int d = 0; d < 8; d++) begin
      if (d != router_id) begin
        route_one(3'(d));
      end
    end
  endtask

  task automatic test_adaptive();
    set_levels(0, 0, 2, 2);
    for (int d = 0; d < 8; d++) begin
      route_one(3'(d));
    end
    repeat (10) begin
      set_levels($urandom % 3, $urandom % 3, $urandom % 3, $urandom % 3);
      route_one(3'($urandom));
    end
  endtask

  // first message parks at the stalled output, four fill the queue, sixth drops
  task automatic test_order_drop();
    ring_net_pkg::ring_msg_t exp_q[$];
    ring_net_pkg::ring_msg_t m;
    set_levels(2, 2, 2, 2);
    // an empty queue has four free entries, which neighbours see as two
    @(negedge clk);
    assert (free_level == 2'd2) else begin
      errors++;
      $display("mismatch free_level: got %h expected 2", free_level);
    end
    @(posedge clk);
    out_stall <= 1'b1;
    for (int i = 0; i < 5; i++) begin
      send_msg(3'(i + 4), 1'b1, m);
      exp_q.push_back(m);
      @(posedge clk);
    end
    send_msg(3'd1, 1'b0, m);
    @(negedge clk);
    assert (drop == 1'b1) else begin
      errors++;
      $display("mismatch drop: got %h expected 1", drop);
    end
    assert (free_level == '0) else begin
      errors++;
      $display("mismatch free_level: got %h expected 0", free_level);
    end
    @(posedge clk);
    out_stall <= 1'b0;
    while (exp_q.size() > 0) begin
      m = exp_q.pop_front();
      check_out(m, expected_request(m.dest));
    end
  endtask

  task automatic test_stall_hold();
    ring_net_pkg::ring_msg_t m;
    logic [2:0]              req;
    @(posedge clk);
    out_stall <= 1'b1;
    send_msg(3'd6, 1'b1, m);
    req = expected_request(3'd6);
    check_out(m, req);
    repeat (4) begin
      @(negedge clk);
      assert (out_val) else begin
        errors++;
        $display("out_val went low while out_stall was held");
      end
      assert (out_reqs == req) else begin
        errors++;
        $display("mismatch out_reqs: got %h expected %h", out_reqs, req);
      end
      assert (out_msg == m) else begin
        errors++;
        $display("mismatch out_msg: got %h expected %h", out_msg, m);
      end
    end
    @(posedge clk);
    out_stall <= 1'b0;
    route_one(3'd0);
  endtask

  //==========================================================================
  // run control
  //==========================================================================

  initial begin
    void'($urandom(32'h4a617cd4));
    errors         = 0;
    checks         = 0;
    seq_next       = '0;
    arst_n         = 1'b0;
    in_val         = 1'b0;
    in_dest        = '0;
    in_payload     = '0;
    forw_free_one  = 2'd2;
    forw_free_two  = 2'd2;
    backw_free_one = 2'd2;
    backw_free_two = 2'd2;
    out_stall      = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    test_terminal();
    test_shortest();
    test_adaptive();
    test_order_drop();
    test_stall_hold();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog in case an output never shows up and a wait loop stalls
  initial begin
    #(timeout_ns);
    $display("timeout after %0d ns, the tests did not complete", timeout_ns);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ring_router_input_top.sv ====
//==========================================================================
// input side of one ring router, injection to route decision
// the switch is outside, out_stall is its only way to hold the output
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module ring_router_input_top #(
  parameter int unsigned router_id = 3
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   in_val,
  input  logic [ring_net_pkg::dest_nbits-1:0]    in_dest,
  input  logic [ring_net_pkg::payload_nbits-1:0] in_payload,
  output logic                                   drop,
  output logic [ring_net_pkg::free_nbits-1:0]    free_level,
  input  logic [ring_net_pkg::free_nbits-1:0]    forw_free_one,
  input  logic [ring_net_pkg::free_nbits-1:0]    forw_free_two,
  input  logic [ring_net_pkg::free_nbits-1:0]    backw_free_one,
  input  logic [ring_net_pkg::free_nbits-1:0]    backw_free_two,
  input  logic                                   out_stall,
  output logic                                   out_val,
  output logic [2:0]                             out_reqs,
  output ring_net_pkg::ring_msg_t                out_msg
);

  // injection register to queue
  logic                                 enq_val;
  ring_net_pkg::ring_msg_t              enq_msg;
  logic [ring_net_pkg::count_nbits-1:0] enq_free;

  // queue head to route stage
  ring_msg_if #(.t_item(ring_net_pkg::ring_msg_t)) q_if ();

  ring_inject #(.router_id(router_id)) inject0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_val     (in_val),
    .in_dest    (in_dest),
    .in_payload (in_payload),
    .enq_free   (enq_free),
    .enq_val    (enq_val),
    .enq_msg    (enq_msg),
    .drop       (drop)
  );

  ring_input_queue #(.t_item(ring_net_pkg::ring_msg_t)) queue0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .enq_val    (enq_val),
    .enq_data   (enq_msg),
    .enq_free   (enq_free),
    .free_level (free_level),
    .q          (q_if.buf_side)
  );

  ring_route_compute #(.router_id(router_id)) route0 (
    .clk            (clk),
    .arst_n         (arst_n),
    .q              (q_if.route_side),
    .forw_free_one  (forw_free_one),
    .forw_free_two  (forw_free_two),
    .backw_free_one (backw_free_one),
    .backw_free_two (backw_free_two),
    .out_stall      (out_stall),
    .out_val        (out_val),
    .out_reqs       (out_reqs),
    .out_msg        (out_msg)
  );

endmodule

`default_nettype wire

// ==== sources.f ====
ring_net_pkg.sv
ring_msg_if.sv
ring_inject.sv
ring_input_queue.sv
ring_route_compute.sv
ring_router_input_top.sv
ring_router_input_assert.sv
ring_router_input_tb.sv
